//--- sobel_pkg.sv
`default_nettype none

package sobel_pkg;

    // frame geometry, kept small for short simulations
    localparam int IMG_COLS = 16;
    localparam int IMG_ROWS = 8;
    localparam int WIN_ROWS = 3;  // kernel height

    typedef logic [7:0]                    pixel_t;  // one grayscale sample
    typedef logic [$clog2(IMG_COLS)-1:0]   col_t;    // column index
    typedef logic [$clog2(IMG_ROWS)-1:0]   row_t;    // row index
    typedef logic signed [10:0]            grad_t;   // +/- 1020
    typedef logic [10:0]                   mag_t;    // |gx| + |gy|, up to 2040

    // edge decision and output levels
    localparam mag_t   THRESHOLD = mag_t'(96);  // edge at or above this
    localparam pixel_t BLACK     = 8'h00;
    localparam pixel_t WHITE     = 8'hff;

    // one accepted pixel with its position in the frame
    typedef struct packed {
        logic   valid;
        pixel_t pixel;
        col_t   col;
        row_t   row;
    } pix_beat_t;

    // pixel one row earlier at the same column
    typedef struct packed {
        pixel_t pix;
    } row_tap_t;

endpackage

`default_nettype wire

//--- pixel_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_sequencer import sobel_pkg::*; (
    input  wire logic   sys_clk,
    input  wire logic   sys_rst_n,
    input  wire logic   in_flag,
    input  wire pixel_t in_data,
    output pix_beat_t   beat
);

    col_t col_cnt;  // column of the next pixel
    row_t row_cnt;  // row of the next pixel
    logic col_last;

    assign col_last = (col_cnt == col_t'(IMG_COLS - 1));

    // column counter, wraps at end of line
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            col_cnt <= '0;
        end else if (in_flag) begin
            if (col_last) begin
                col_cnt <= '0;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // row counter steps when the column wraps
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            row_cnt <= '0;
        end else if (in_flag && col_last) begin
            if (row_cnt == row_t'(IMG_ROWS - 1)) begin
                row_cnt <= '0;  // new frame
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // pixel goes out with the position it was received at
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            beat <= '0;
        end else begin
            beat.valid <= in_flag;  // one cycle only
            if (in_flag) begin
                beat.pixel <= in_data;
                beat.col   <= col_cnt;
                beat.row   <= row_cnt;
            end
        end
    end

endmodule

`default_nettype wire

//--- line_delay.sv
`timescale 1ns/1ps
`default_nettype none

module line_delay import sobel_pkg::*; (
    input  wire logic   sys_clk,
    input  wire logic   sys_rst_n,
    input  wire logic   push,
    input  wire col_t   col,
    input  wire pixel_t din,
    output row_tap_t    tap
);

    // one full row of pixels, addressed by column
    pixel_t mem [IMG_COLS];

    // read before write: the old entry is the pixel one row up
    assign tap.pix = mem[col];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < IMG_COLS; i++) begin
                mem[i] <= '0;
            end
        end else if (push) begin
            mem[col] <= din;  // overwrite with the current row
        end
    end

endmodule

`default_nettype wire

//--- sobel_window.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_window import sobel_pkg::*; (
    input  wire logic      sys_clk,
    input  wire logic      sys_rst_n,
    input  wire pix_beat_t beat,
    input  wire row_tap_t  tap_prev,
    input  wire row_tap_t  tap_prev2,
    output logic           out_flag,
    output pixel_t         out_data
);

    // 3x3 window, right column is the newest
    pixel_t top_l, top_c, top_r;
    pixel_t mid_l, mid_c, mid_r;
    pixel_t bot_l, bot_c, bot_r;

    logic  win_ready;   // window complete, stage 1
    logic  grad_valid;  // gx and gy loaded, stage 2
    grad_t gx;
    grad_t gy;
    mag_t  mag;

    // 1-2-1 weighted sum of three pixels
    function automatic grad_t wsum(pixel_t a, pixel_t b, pixel_t c);
        return grad_t'({3'b000, a}) + grad_t'({2'b00, b, 1'b0}) + grad_t'({3'b000, c});
    endfunction

    function automatic mag_t abs_grad(grad_t g);
        return g[10] ? mag_t'(-g) : mag_t'(g);
    endfunction

    // shift in a new column on every accepted pixel
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            top_l <= '0;
            top_c <= '0;
            top_r <= '0;
            mid_l <= '0;
            mid_c <= '0;
            mid_r <= '0;
            bot_l <= '0;
            bot_c <= '0;
            bot_r <= '0;
        end else if (beat.valid) begin
            top_l <= top_c;
            top_c <= top_r;
            top_r <= tap_prev2.pix;  // two rows up
            mid_l <= mid_c;
            mid_c <= mid_r;
            mid_r <= tap_prev.pix;
            bot_l <= bot_c;
            bot_c <= bot_r;
            bot_r <= beat.pixel;     // current row
        end
    end

    // border pixels never produce a result
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            win_ready <= 1'b0;
        end else begin
            win_ready <= beat.valid && (beat.col >= col_t'(2)) && (beat.row >= row_t'(2));
        end
    end

    // gradients
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            grad_valid <= 1'b0;
            gx         <= '0;
            gy         <= '0;
        end else begin
            grad_valid <= win_ready;
            if (win_ready) begin
                gx <= wsum(top_r, mid_r, bot_r) - wsum(top_l, mid_l, bot_l);
                gy <= wsum(top_l, top_c, top_r) - wsum(bot_l, bot_c, bot_r);
            end
        end
    end

    assign mag = abs_grad(gx) + abs_grad(gy);

    // threshold and output register
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            out_flag <= 1'b0;
            out_data <= '0;
        end else begin
            out_flag <= grad_valid;
            if (grad_valid) begin
                out_data <= (mag >= THRESHOLD) ? BLACK : WHITE;
            end
        end
    end

endmodule

`default_nettype wire

//--- sobel_edge_top.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_edge_top import sobel_pkg::*; (
    input  wire logic   sys_clk,
    input  wire logic   sys_rst_n,
    input  wire logic   in_flag,
    input  wire pixel_t in_data,
    output logic        out_flag,
    output pixel_t      out_data
);

    wire pix_beat_t beat;
    wire row_tap_t  taps     [WIN_ROWS-1];  // 0 is previous row, 1 is two rows up
    wire pixel_t    line_din [WIN_ROWS-1];

    pixel_sequencer u_pixel_sequencer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_flag   (in_flag),
        .in_data   (in_data),
        .beat      (beat)
    );

    // row history, each delay feeds the next
    for (genvar i = 0; i < WIN_ROWS - 1; i++) begin : g_line
        if (i == 0) begin : g_first
            assign line_din[i] = beat.pixel;
        end else begin : g_chain
            assign line_din[i] = taps[i-1].pix;
        end

        line_delay u_line_delay (
            .sys_clk   (sys_clk),
            .sys_rst_n (sys_rst_n),
            .push      (beat.valid),
            .col       (beat.col),
            .din       (line_din[i]),
            .tap       (taps[i])
        );
    end

    sobel_window u_sobel_window (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .beat      (beat),
        .tap_prev  (taps[0]),
        .tap_prev2 (taps[1]),
        .out_flag  (out_flag),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic sys_clk,
    output logic sys_rst_n
);

    localparam int HALF_NS    = 10;  // 20 ns period
    localparam int RST_CYCLES = 8;

    initial begin
        sys_clk = 1'b0;
        forever #(HALF_NS) sys_clk = ~sys_clk;
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;  // release clear of the edge
    end

endmodule

`default_nettype wire

//--- sobel_edge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_edge_checker import sobel_pkg::*; (
    input wire logic   sys_clk,
    input wire logic   sys_rst_n,
    input wire logic   in_flag,
    input wire logic   out_flag,
    input wire pixel_t out_data
);

    localparam int LATENCY = 4;  // sampling edge to sampled out_flag

    // output strobe always resolved once out of reset
    a_flag_known: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !$isunknown(out_flag)
    ) else $error("out_flag is unknown");

    // only the two legal output levels
    a_data_level: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        out_flag |-> (out_data == BLACK || out_data == WHITE)
    ) else $error("out_data %h is neither black nor white", out_data);

    // every result traces back to an accepted pixel
    a_latency: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        out_flag |-> $past(in_flag, LATENCY)
    ) else $error("out_flag without a pixel %0d cycles earlier", LATENCY);

endmodule

`default_nettype wire

//--- sobel_edge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_edge_tb import sobel_pkg::*; ();

    localparam int NUM_FRAMES = 5;
    localparam int OUTS_PER_FRAME = (IMG_ROWS - 2) * (IMG_COLS - 2);
    localparam int LATENCY    = 4;
    localparam int STEP_COL   = 8;
    localparam int STEP_ROW   = 4;
    localparam int CLK_NS     = 20;
    localparam int MARGIN     = 200;  // reset plus pipeline drain
    localparam logic [31:0] SEED = 32'h5dd9_42fc;

    typedef enum logic [1:0] {PAT_FLAT, PAT_VSTEP, PAT_HSTEP, PAT_RAND} pat_kind_t;

    typedef struct packed {
        pat_kind_t kind;
        logic      rand_gap;   // 0 to 3 idle cycles between pixels
        int        exp_black;  // -1 when the model alone decides
    } frame_cfg_t;

    typedef struct packed {
        pixel_t value;
        int     frame_idx;
        int     in_edge;  // edge that samples the completing pixel
    } exp_item_t;

    frame_cfg_t frame_tbl [NUM_FRAMES] = '{
        '{PAT_FLAT,  1'b0, 0},
        '{PAT_VSTEP, 1'b0, 2 * (IMG_ROWS - 2)},
        '{PAT_HSTEP, 1'b1, 2 * (IMG_COLS - 2)},
        '{PAT_RAND,  1'b1, -1},
        '{PAT_RAND,  1'b0, -1}
    };

    logic   sys_clk;
    logic   sys_rst_n;
    logic   in_flag;
    pixel_t in_data;
    logic   out_flag;
    pixel_t out_data;

    logic [31:0] rng;
    int          img [IMG_ROWS][IMG_COLS];  // frame being sent
    exp_item_t   exp_q [$];
    exp_item_t   got_item;
    int          edge_cnt = 0;
    int          err_cnt = 0;
    int          checked = 0;
    int          frames_done = 0;
    int          out_cnt   [NUM_FRAMES];
    int          black_cnt [NUM_FRAMES];
    int          frame_err [NUM_FRAMES];

    tb_clk_gen u_tb_clk_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    sobel_edge_top u_sobel_edge_top (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_flag   (in_flag),
        .in_data   (in_data),
        .out_flag  (out_flag),
        .out_data  (out_data)
    );

    bind sobel_edge_top sobel_edge_checker u_sobel_edge_checker (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_flag   (in_flag),
        .out_flag  (out_flag),
        .out_data  (out_data)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic pixel_t pattern_pixel(pat_kind_t kind, int r, int c, logic [31:0] rnd);
        case (kind)
            PAT_FLAT:  return 8'd90;
            PAT_VSTEP: return (c < STEP_COL) ? 8'd0 : 8'd200;
            PAT_HSTEP: return (r < STEP_ROW) ? 8'd0 : 8'd200;
            default:   return rnd[7:0];
        endcase
    endfunction

    // reference Sobel for the stored window ending at (r, c)
    function automatic pixel_t sobel_expect(int r, int c);
        int gx;
        int gy;
        int mag;
        gx = (img[r-2][c] + 2 * img[r-1][c] + img[r][c])
           - (img[r-2][c-2] + 2 * img[r-1][c-2] + img[r][c-2]);
        gy = (img[r-2][c-2] + 2 * img[r-2][c-1] + img[r-2][c])
           - (img[r][c-2] + 2 * img[r][c-1] + img[r][c]);
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        return (mag >= int'(THRESHOLD)) ? BLACK : WHITE;
    endfunction

    task automatic report_frame(int f);
        if (frame_tbl[f].exp_black >= 0 && black_cnt[f] != frame_tbl[f].exp_black) begin
            $display("FAILED t=%0t black count of frame %0d expected %0d got %0d",
                     $time, f, frame_tbl[f].exp_black, black_cnt[f]);
            frame_err[f]++;
            err_cnt++;
        end
        $display("frame %0d %s gaps=%0d: %0d outputs, %0d black, %0d errors",
                 f, frame_tbl[f].kind.name(), frame_tbl[f].rand_gap,
                 out_cnt[f], black_cnt[f], frame_err[f]);
        frames_done++;
    endtask

    always @(posedge sys_clk) edge_cnt <= edge_cnt + 1;

    // output monitor on the falling edge
    always @(negedge sys_clk) begin
        if (out_flag) begin
            if (exp_q.size() == 0) begin
                $display("t=%0t: out_flag high while no complete window is pending", $time);
                err_cnt++;
            end else begin
                got_item = exp_q.pop_front();
                checked++;
                if (out_data !== got_item.value) begin
                    $display("FAILED t=%0t out_data expected %h got %h",
                             $time, got_item.value, out_data);
                    frame_err[got_item.frame_idx]++;
                    err_cnt++;
                end
                if (edge_cnt + 1 - got_item.in_edge != LATENCY) begin
                    $display("FAILED t=%0t out_flag latency expected %0d got %0d",
                             $time, LATENCY, edge_cnt + 1 - got_item.in_edge);
                    frame_err[got_item.frame_idx]++;
                    err_cnt++;
                end
                out_cnt[got_item.frame_idx]++;
                if (out_data == BLACK) black_cnt[got_item.frame_idx]++;
                if (out_cnt[got_item.frame_idx] == OUTS_PER_FRAME) begin
                    report_frame(got_item.frame_idx);
                end
            end
        end
    end

    // frames go out one after another with no pause
    initial begin
        pixel_t pix;
        int     gap;
        in_flag = 1'b0;
        in_data = '0;
        rng     = SEED;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            out_cnt[f]   = 0;
            black_cnt[f] = 0;
            frame_err[f] = 0;
        end
        wait (sys_rst_n === 1'b1);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int r = 0; r < IMG_ROWS; r++) begin
                for (int c = 0; c < IMG_COLS; c++) begin
                    rng = xorshift32(rng);
                    pix = pattern_pixel(frame_tbl[f].kind, r, c, rng);
                    img[r][c] = int'(pix);
                    @(posedge sys_clk);
                    #1;
                    in_flag = 1'b1;
                    in_data = pix;
                    if (r >= 2 && c >= 2) begin
                        exp_q.push_back('{sobel_expect(r, c), f, edge_cnt + 1});
                    end
                    rng = xorshift32(rng);
                    gap = frame_tbl[f].rand_gap ? int'(rng[1:0]) : 0;
                    repeat (gap) begin
                        @(posedge sys_clk);
                        #1;
                        in_flag = 1'b0;
                    end
                end
            end
        end
        @(posedge sys_clk);
        #1;
        in_flag = 1'b0;
        wait (frames_done == NUM_FRAMES);
        repeat (8) @(posedge sys_clk);  // catch stray outputs
        $display("summary: %0d frames, %0d outputs checked, %0d errors",
                 frames_done, checked, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = MARGIN;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            cycles += IMG_ROWS * IMG_COLS * (frame_tbl[f].rand_gap ? 4 : 1);
        end
        #(cycles * CLK_NS);
        $display("watchdog: run did not finish within %0d cycles", cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
sobel_pkg.sv
pixel_sequencer.sv
line_delay.sv
sobel_window.sv
sobel_edge_top.sv
tb_clk_gen.sv
sobel_edge_checker.sv
sobel_edge_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = sobel_edge_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
